// ==== logic/apb_slave_fsm.sv ====
// APB slave for the mailbox: one wait state, register decode, ctrl register and pop
`timescale 1ns/1ps

module apb_slave_fsm
   import mbox_regs_pkg::*;
(
   input  logic               rd_clk,
   input  logic               rst_n,
   input  logic               psel,
   input  logic               penable,
   input  logic               pwrite,
   input  logic [7:0]         paddr,
   input  mbox_word_t         pwdata,
   output mbox_word_t         prdata,
   output logic               pready,
   output logic               pslverr,
   input  logic [entry_w-1:0] rd_data,
   input  logic               empty,
   input  logic               full,
   output logic               pop,
   output logic               irq_en
);

   apb_state_e state;
   apb_state_e state_nxt;
   mbox_word_t rdata_mux;   // read data selected during ap_wait
   mbox_word_t status_word;
   mbox_word_t ctrl_word;
   logic       dec_err;     // bad address or write to a ro register
   logic       err_q;
   logic       hi_rd_q;     // successful mailbox_hi read, pops in ap_done
   logic       ctrl_wr_q;

   // status and control words
   always_comb
   begin
      status_word = '0;
      status_word[stat_not_empty_bit] = ~empty;
      status_word[stat_full_bit]      = full;
      ctrl_word = '0;
      ctrl_word[ctrl_irq_en_bit] = irq_en;
   end

   // address decode, only sampled in ap_wait
   always_comb
   begin
      dec_err   = 1'b0;
      rdata_mux = '0;
      case (paddr)
         reg_mailbox_lo:
         begin
            dec_err   = pwrite;
            rdata_mux = rd_data[31:0];
         end
         reg_mailbox_hi:
         begin
            dec_err   = pwrite;
            rdata_mux = rd_data[63:32];   // entry before the pop
         end
         reg_status:
         begin
            dec_err   = pwrite;
            rdata_mux = status_word;
         end
         reg_ctrl:       rdata_mux = ctrl_word;
         default:        dec_err   = 1'b1;   // unmapped offset
      endcase
      if (pwrite || dec_err)
         rdata_mux = '0;   // no read data on writes or errors
   end

   // handshake: setup -> wait -> done -> idle
   always_comb
   begin
      state_nxt = state;
      case (state)
         ap_idle: if (psel && !penable) state_nxt = ap_wait;
         ap_wait: if (psel && penable)  state_nxt = ap_done;
         ap_done:                       state_nxt = ap_idle;
         default:                       state_nxt = ap_idle;
      endcase
   end

   always_ff @(posedge rd_clk)
   begin
      if (!rst_n)
      begin
         state     <= ap_idle;
         err_q     <= 1'b0;
         hi_rd_q   <= 1'b0;
         ctrl_wr_q <= 1'b0;
         irq_en    <= 1'b0;
      end
      else
      begin
         state <= state_nxt;
         if (state == ap_wait)
         begin
            err_q     <= dec_err;
            hi_rd_q   <= ~pwrite & ~dec_err & (paddr == reg_mailbox_hi);
            ctrl_wr_q <= pwrite & (paddr == reg_ctrl);
         end
         // master holds pwdata through ap_done
         if (state == ap_done && ctrl_wr_q)
            irq_en <= pwdata[ctrl_irq_en_bit];
      end
   end

   // read data, payload register
   always_ff @(posedge rd_clk)
   begin
      if (state == ap_wait)
         prdata <= rdata_mux;
   end

   assign pready  = (state == ap_done);
   assign pslverr = pready & err_q;
   assign pop     = pready & hi_rd_q;   // one cycle strobe

endmodule

// ==== logic/mailbox_top.sv ====
// mailbox top level: mesh decoder, FIFO, APB slave and the level interrupt
`timescale 1ns/1ps

module mailbox_top
   import mesh_pkg::*, mbox_regs_pkg::*;
(
   input  logic                rd_clk,
   input  logic                rst_n,
   input  logic                mesh_access,
   input  logic [packet_w-1:0] mesh_packet,
   input  logic                psel,
   input  logic                penable,
   input  logic                pwrite,
   input  logic [7:0]          paddr,
   input  mbox_word_t          pwdata,
   output mbox_word_t          prdata,
   output logic                pready,
   output logic                pslverr,
   output logic                mailbox_irq
);

   logic               push;
   logic [entry_w-1:0] push_data;
   logic               pop;
   logic               mem_we;
   logic [ptr_w-1:0]   wr_ptr;
   logic [ptr_w-1:0]   rd_ptr;
   logic               empty;
   logic               full;
   logic [entry_w-1:0] rd_data;
   logic               irq_en;

   mesh_decode u_decode (
      .mesh_access (mesh_access),
      .mesh_packet (mesh_packet),
      .push        (push),
      .push_data   (push_data)
   );

   mbox_ptr_ctrl u_ptr (
      .rd_clk (rd_clk),
      .rst_n  (rst_n),
      .push   (push),
      .pop    (pop),
      .mem_we (mem_we),
      .wr_ptr (wr_ptr),
      .rd_ptr (rd_ptr),
      .empty  (empty),
      .full   (full)
   );

   mbox_fifo_mem u_mem (
      .rd_clk    (rd_clk),
      .mem_we    (mem_we),
      .wr_ptr    (wr_ptr),
      .rd_ptr    (rd_ptr),
      .push_data (push_data),
      .rd_data   (rd_data)
   );

   apb_slave_fsm u_apb (
      .rd_clk  (rd_clk),
      .rst_n   (rst_n),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .rd_data (rd_data),
      .empty   (empty),
      .full    (full),
      .pop     (pop),
      .irq_en  (irq_en)
   );

   // level irq while anything is queued
   assign mailbox_irq = irq_en & (~empty | full);

endmodule

// ==== logic/mbox_fifo_mem.sv ====
// mailbox FIFO storage: 32 x 64 array, registered write, head entry read async
`timescale 1ns/1ps

module mbox_fifo_mem
   import mbox_regs_pkg::*;
(
   input  logic               rd_clk,
   input  logic               mem_we,
   input  logic [ptr_w-1:0]   wr_ptr,
   input  logic [ptr_w-1:0]   rd_ptr,
   input  logic [entry_w-1:0] push_data,
   output logic [entry_w-1:0] rd_data
);

   logic [entry_w-1:0] mem [fifo_depth];

   // write port, already qualified against full
   always_ff @(posedge rd_clk)
   begin
      if (mem_we)
         mem[wr_ptr] <= push_data;
   end

   // head of queue always visible to the APB side
   // stale when empty, nothing popped then
   assign rd_data = mem[rd_ptr];

endmodule

// ==== logic/mbox_ptr_ctrl.sv ====
// mailbox FIFO pointer control: read/write pointers, occupancy, empty and full
`timescale 1ns/1ps

module mbox_ptr_ctrl
   import mbox_regs_pkg::*;
(
   input  logic             rd_clk,
   input  logic             rst_n,
   input  logic             push,
   input  logic             pop,
   output logic             mem_we,
   output logic [ptr_w-1:0] wr_ptr,
   output logic [ptr_w-1:0] rd_ptr,
   output logic             empty,
   output logic             full
);

   logic [cnt_w-1:0] count;   // entries held
   logic             push_ok;
   logic             pop_ok;

   // flags straight from the count
   assign empty = (count == '0);
   assign full  = (count == cnt_w'(fifo_depth));

   // overflow and underflow refused here only
   assign push_ok = push & ~full;   // full seen before any pop in the same cycle
   assign pop_ok  = pop & ~empty;
   assign mem_we  = push_ok;

   always_ff @(posedge rd_clk)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push_ok)
            wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
         if (pop_ok)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push_ok, pop_ok})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // none, or both cancel out
         endcase
      end
   end

endmodule

// ==== logic/mbox_regs_pkg.sv ====
// mailbox register package: register map, FIFO geometry and APB states
package mbox_regs_pkg;

   // host side register word
   typedef logic [31:0] mbox_word_t;

   // fifo geometry
   localparam int fifo_depth = 32;
   localparam int ptr_w      = 5;
   localparam int cnt_w      = ptr_w + 1;   // occupancy, 0 to fifo_depth
   localparam int entry_w    = 64;          // {src addr, data}

   // byte offsets in the 8 bit APB address space
   localparam logic [7:0] reg_mailbox_lo = 8'h00;   // ro, also mesh target offset
   localparam logic [7:0] reg_mailbox_hi = 8'h04;   // ro, read pops the entry
   localparam logic [7:0] reg_status     = 8'h08;   // ro, [0] not_empty [1] full
   localparam logic [7:0] reg_ctrl       = 8'h0c;   // rw, [0] irq_en

   // status and control bit positions
   localparam int stat_not_empty_bit = 0;
   localparam int stat_full_bit      = 1;
   localparam int ctrl_irq_en_bit    = 0;

   // APB slave handshake states
   typedef enum logic [1:0] {
      ap_idle = 2'd0,
      ap_wait = 2'd1,   // first access cycle, pready low
      ap_done = 2'd2    // second access cycle, pready high
   } apb_state_e;

endpackage

// ==== logic/mesh_decode.sv ====
// mesh packet decoder: unpacks a packet and requests a FIFO push on mailbox writes
`timescale 1ns/1ps

module mesh_decode
   import mesh_pkg::*, mbox_regs_pkg::*;
(
   input  logic                mesh_access,
   input  logic [packet_w-1:0] mesh_packet,
   output logic                push,
   output logic [entry_w-1:0]  push_data
);

   mesh_op_e    op;
   logic [31:0] dst_addr;
   logic [31:0] data_fld;
   logic [31:0] src_addr;
   logic        node_hit;
   logic        group_hit;
   logic        offset_hit;

   // field split
   assign op       = mesh_op_e'(mesh_packet[op_msb:op_lsb]);
   assign dst_addr = mesh_packet[dst_msb:dst_lsb];
   assign data_fld = mesh_packet[data_msb:data_lsb];
   assign src_addr = mesh_packet[src_msb:src_lsb];

   // address match against this node's mailbox register
   assign node_hit   = (dst_addr[31:20] == node_id);
   assign group_hit  = (dst_addr[19:16] == group_mmr);
   assign offset_hit = (dst_addr[7:2] == reg_mailbox_lo[7:2]);   // word offset only

   // same cycle as the access, ptr ctrl decides if it is taken
   assign push = mesh_access & (op == mop_write) & node_hit & group_hit & offset_hit;

   // low word is the payload, high word tells the host who sent it
   assign push_data = {src_addr, data_fld};

endmodule

// ==== logic/mesh_pkg.sv ====
// mesh packet package: packet layout, opcodes and identity of this node
package mesh_pkg;

   // packet geometry
   localparam int packet_w = 104;

   // field positions within the packet
   localparam int op_lsb   = 0;
   localparam int op_msb   = 7;
   localparam int dst_lsb  = 8;
   localparam int dst_msb  = 39;
   localparam int data_lsb = 40;
   localparam int data_msb = 71;
   localparam int src_lsb  = 72;
   localparam int src_msb  = 103;

   // packet opcodes, 8 bit field
   typedef enum logic [7:0] {
      mop_read   = 8'h00,
      mop_write  = 8'h01,
      mop_atomic = 8'h02   // not serviced by the mailbox
   } mesh_op_e;

   // identity of this node on the mesh
   localparam logic [11:0] node_id   = 12'h81a;   // matched against dst addr [31:20]
   localparam logic [3:0]  group_mmr = 4'hf;      // register group, dst addr [19:16]

endpackage

// ==== src.f ====
logic/mesh_pkg.sv
logic/mbox_regs_pkg.sv
logic/mesh_decode.sv
logic/mbox_ptr_ctrl.sv
logic/mbox_fifo_mem.sv
logic/apb_slave_fsm.sv
logic/mailbox_top.sv
test/mailbox_assert.sv
test/mailbox_tb.sv

// ==== test/mailbox_assert.sv ====
// APB handshake and FIFO flag checker bound into the mailbox APB slave
`timescale 1ns/1ps

module mailbox_assert
   import mbox_regs_pkg::*;
(
   input logic       rd_clk,
   input logic       rst_n,
   input logic       psel,
   input logic       penable,
   input logic       pwrite,
   input logic [7:0] paddr,
   input logic       pready,
   input logic       pop,
   input logic       empty,
   input logic       full
);

   int fail_count = 0;   // polled by the testbench at the end

   a_ready_in_access: assert property (@(posedge rd_clk) disable iff (!rst_n)
      pready |-> (psel && penable))   // only inside an access phase
      else
      begin
         fail_count++;
         $error("pready high without psel and penable");
      end

   // setup then one wait state and a single pready cycle
   a_ready_one_cycle: assert property (@(posedge rd_clk) disable iff (!rst_n)
      (psel && !penable) |=> !pready ##1 pready ##1 !pready)
      else
      begin
         fail_count++;
         $error("pready not after exactly one wait state or held too long");
      end

   a_pop_with_ready: assert property (@(posedge rd_clk) disable iff (!rst_n)
      pop == (pready && !pwrite && (paddr == reg_mailbox_hi)))   // strobe only on a hi read
      else
      begin
         fail_count++;
         $error("pop does not match a completing mailbox_hi read");
      end

   a_pop_leaves_room: assert property (@(posedge rd_clk) disable iff (!rst_n)
      (pop && !empty) |=> !full)   // no push accepted while full
      else
      begin
         fail_count++;
         $error("FIFO still full after a pop");
      end

endmodule

bind apb_slave_fsm mailbox_assert u_apb_chk (
   .rd_clk  (rd_clk),
   .rst_n   (rst_n),
   .psel    (psel),
   .penable (penable),
   .pwrite  (pwrite),
   .paddr   (paddr),
   .pready  (pready),
   .pop     (pop),
   .empty   (empty),
   .full    (full)
);

// ==== test/mailbox_tb.sv ====
// mailbox testbench: directed mesh and APB tests against the mailbox top level
`timescale 1ns/1ps

module mailbox_tb
   import mesh_pkg::*, mbox_regs_pkg::*;
();

   localparam int n_xfers   = 85;   // APB transfers over all tests
   localparam int n_pkts    = 39;   // mesh packets over all tests
   localparam int wd_cycles = n_xfers * 3 + n_pkts + 200;
   localparam logic [31:0] mbox_addr = {node_id, group_mmr, 8'h00, reg_mailbox_lo};

   logic                rd_clk = 1'b0;
   logic                rst_n;
   logic                mesh_access;
   logic [packet_w-1:0] mesh_packet;
   logic                psel;
   logic                penable;
   logic                pwrite;
   logic [7:0]          paddr;
   mbox_word_t          pwdata;
   mbox_word_t          prdata;
   logic                pready;
   logic                pslverr;
   logic                mailbox_irq;

   always #20 rd_clk = ~rd_clk;   // 40 ns

   mailbox_top DUT (.*);

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1, "stopped on first error");
   endtask

   task automatic check_word(input string name, input mbox_word_t got, input mbox_word_t exp);
      if (got !== exp)
         abort_run($sformatf("CHECK FAILED: %s got 0x%08h expected 0x%08h", name, got, exp));
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
         abort_run($sformatf("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   // three cycle transfer with results sampled mid cycle
   task automatic apb_xfer(input logic wr, input logic [7:0] addr, input mbox_word_t wdata,
                           output mbox_word_t rdata, output logic err);
      int waits;
      waits = 0;
      @(posedge rd_clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= addr;
      pwdata  <= wdata;
      @(posedge rd_clk);
      penable <= 1'b1;
      do
      begin
         @(negedge rd_clk);
         waits++;
      end
      while (!pready);   // watchdog covers a missing pready
      if (waits != 2)
         abort_run("pready did not come after exactly one wait state");
      rdata = prdata;
      err   = pslverr;
      @(posedge rd_clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic apb_read(input logic [7:0] addr, output mbox_word_t data, output logic err);
      apb_xfer(1'b0, addr, '0, data, err);
   endtask

   task automatic apb_write(input logic [7:0] addr, input mbox_word_t data, output logic err);
      mbox_word_t unused;
      apb_xfer(1'b1, addr, data, unused, err);
   endtask

   // pslverr on every transfer and read data on good reads only
   task automatic access_check(input logic wr, input logic [7:0] addr, input mbox_word_t wdata,
                               input mbox_word_t exp_rd, input logic exp_err);
      mbox_word_t rd;
      logic       err;
      if (wr)
         apb_write(addr, wdata, err);
      else
         apb_read(addr, rd, err);
      check_flag($sformatf("pslverr@%02h", addr), err, exp_err);
      if (!wr && !exp_err)
         check_word($sformatf("prdata@%02h", addr), rd, exp_rd);
   endtask

   function automatic logic [packet_w-1:0] make_packet(input mesh_op_e op,
         input logic [31:0] dst, input logic [31:0] data, input logic [31:0] src);
      return {src, data, dst, op};
   endfunction

   task automatic mesh_send(input logic [packet_w-1:0] pkt);
      @(posedge rd_clk);
      mesh_access <= 1'b1;
      mesh_packet <= pkt;
      @(posedge rd_clk);
      mesh_access <= 1'b0;   // single cycle strobe
   endtask

   task automatic irq_expect(input logic exp);
      @(negedge rd_clk);
      check_flag("mailbox_irq", mailbox_irq, exp);
   endtask

   task automatic test_reset();
      irq_expect(1'b0);
      access_check(1'b0, reg_status, '0, 32'h0, 1'b0);
      access_check(1'b0, reg_ctrl, '0, 32'h0, 1'b0);
   endtask

   task automatic test_single_packet();
      mbox_word_t d = $urandom();
      mbox_word_t s = $urandom();
      mesh_send(make_packet(mop_write, mbox_addr, d, s));
      access_check(1'b0, reg_mailbox_lo, '0, d, 1'b0);   // data field
      access_check(1'b0, reg_mailbox_hi, '0, s, 1'b0);   // source address and pop
      access_check(1'b0, reg_status, '0, 32'h0, 1'b0);
   endtask

   task automatic test_ignored_packets();
      logic [packet_w-1:0] pkts [4];
      pkts[0] = make_packet(mop_write, {node_id ^ 12'h001, group_mmr, 16'h0000}, 1, 2);
      pkts[1] = make_packet(mop_write, {node_id, group_mmr ^ 4'h1, 16'h0000}, 3, 4);
      pkts[2] = make_packet(mop_write, {node_id, group_mmr, 16'h0004}, 5, 6);   // hi offset
      pkts[3] = make_packet(mop_read, mbox_addr, 7, 8);
      foreach (pkts[i])
      begin
         mesh_send(pkts[i]);
         access_check(1'b0, reg_status, '0, 32'h0, 1'b0);
      end
   endtask

   task automatic test_fill_drain();
      mbox_word_t q_d[$];
      mbox_word_t q_s[$];
      access_check(1'b1, reg_ctrl, 32'h1, '0, 1'b0);   // irq_en on
      access_check(1'b0, reg_ctrl, '0, 32'h1, 1'b0);   // irq_en reads back
      for (int i = 0; i < fifo_depth; i++)
      begin
         q_d.push_back($urandom());
         q_s.push_back($urandom());
         mesh_send(make_packet(mop_write, mbox_addr, q_d[i], q_s[i]));
      end
      access_check(1'b0, reg_status, '0, 32'h3, 1'b0);   // not_empty and full
      irq_expect(1'b1);
      mesh_send(make_packet(mop_write, mbox_addr, ~q_d[0], ~q_s[0]));   // dropped
      access_check(1'b0, reg_status, '0, 32'h3, 1'b0);
      for (int i = 0; i < fifo_depth; i++)
      begin
         irq_expect(1'b1);
         access_check(1'b0, reg_mailbox_lo, '0, q_d[i], 1'b0);
         access_check(1'b0, reg_mailbox_hi, '0, q_s[i], 1'b0);
      end
      irq_expect(1'b0);   // falls after last pop
      access_check(1'b0, reg_status, '0, 32'h0, 1'b0);
   endtask

   task automatic test_masked_and_errors();
      mbox_word_t d = $urandom();
      mbox_word_t s = $urandom();
      access_check(1'b1, reg_ctrl, 32'h0, '0, 1'b0);
      mesh_send(make_packet(mop_write, mbox_addr, d, s));
      irq_expect(1'b0);
      access_check(1'b0, reg_status, '0, 32'h1, 1'b0);
      access_check(1'b1, reg_status, 32'hffff_ffff, '0, 1'b1);   // ro register
      access_check(1'b0, 8'h10, '0, '0, 1'b1);   // unmapped
      access_check(1'b0, reg_status, '0, 32'h1, 1'b0);   // entry untouched
      access_check(1'b0, reg_mailbox_lo, '0, d, 1'b0);
      access_check(1'b0, reg_mailbox_hi, '0, s, 1'b0);
   endtask

   initial
   begin
      repeat (wd_cycles) @(posedge rd_clk);
      abort_run("watchdog expired, pready never came or a test stalled");
   end

   initial
   begin
      void'($urandom(32'h43c4));
      rst_n       = 1'b0;
      mesh_access = 1'b0;
      mesh_packet = '0;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      repeat (8) @(posedge rd_clk);
      rst_n <= 1'b1;
      test_reset();
      test_single_packet();
      test_ignored_packets();
      test_fill_drain();
      test_masked_and_errors();
      repeat (2) @(posedge rd_clk);
      if (DUT.u_apb.u_apb_chk.fail_count == 0)
      begin
         $display("Simulation completed successfully");
      end
      else
      begin
         $display("concurrent assertions in the APB checker failed");
         $display("Simulation failed");
      end
      $finish;
   end

endmodule
